/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_compressed_decoder -f sim.f -o sim_tb

# the pass message decides the result, not the exit status of the run
output=$(./obj_dir/sim_tb +verilator+error+limit+1000) || true
echo "$output"
echo "$output" | grep -q '^\*\*\* PASSED \*\*\*$'

/* sim.f */
verilog/riscv_isa_pkg.sv
verilog/cdec_pkg.sv
verilog/c0_decoder.sv
verilog/c1_decoder.sv
verilog/c2_decoder.sv
verilog/compressed_decoder_stage.sv
testbench/compressed_decoder_asserts.sv
testbench/tb_compressed_decoder.sv

/* testbench/compressed_decoder_asserts.sv */
module compressed_decoder_asserts (
  input logic               clk,
  input logic               reset_i,
  input cdec_pkg::fetch_t   fetch_i,
  input cdec_pkg::dec_out_t dec_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // number of assertion failures, summed into the testbench totals
  int fail_count = 0;

  // output register comes out of reset empty
  valid_low_after_reset: assert property (@(posedge clk) reset_i |=> !dec_i.valid)
    else begin
      fail_count++;
      $error("dec valid high on the cycle after reset");
    end

  // only a 16 bit parcel can be reserved
  illegal_only_compressed: assert property (
    @(posedge clk) disable iff (reset_i) dec_i.illegal |-> dec_i.is_compressed)
    else begin
      fail_count++;
      $error("illegal flag set on a full-width word");
    end

  // full-width words leave the stage unchanged one cycle later
  rv32_word_unchanged: assert property (
    @(posedge clk) disable iff (reset_i)
    (dec_i.valid && !dec_i.is_compressed) |-> (dec_i.instr == $past(fetch_i.rdata)))
    else begin
      fail_count++;
      $error("pass-through word differs from the fetched word");
    end

endmodule

bind compressed_decoder_stage compressed_decoder_asserts compressed_decoder_asserts_inst (
  .clk     (clk),
  .reset_i (reset_i),
  .fetch_i (fetch_i),
  .dec_i   (dec_o)
);

/* testbench/tb_compressed_decoder.sv */
module tb_compressed_decoder;

  timeunit 1ns;
  timeprecision 100ps;

  import riscv_isa_pkg::*;
  import cdec_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int STREAM_LEN   = 20;
  // two cycles per directed parcel plus reset and the stream, with margin
  localparam int TEST_CYCLES    = 200;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic     clk;
  logic     reset_i;
  fetch_t   fetch_i;
  dec_out_t dec_o;

  int cycle_count = 0;
  int check_count = 0;
  int error_count = 0;
  int test_count  = 0;
  int seed;

  compressed_decoder_stage compressed_decoder_stage_inst (
    .clk     (clk),
    .reset_i (reset_i),
    .fetch_i (fetch_i),
    .dec_o   (dec_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // hard stop if the sequence never reaches its end
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timed out after %0d cycles without finishing the tests", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // check and report helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    $display("test %s finished with %0d errors", name, error_count - errors_before);
  endtask

  // drives one parcel with junk in the upper half, checks it one cycle later
  task automatic apply_parcel(input string name, input instr16_t parcel,
                              input instr32_t exp_instr, input logic exp_illegal);
    @(posedge clk);
    fetch_i <= '{valid: 1'b1, rdata: {16'ha5a5, parcel}};
    @(posedge clk);
    @(negedge clk);
    // flags are valid, is_compressed, illegal
    check_value({name, " flags"}, 32'({2'b11, exp_illegal}),
                32'({dec_o.valid, dec_o.is_compressed, dec_o.illegal}));
    // expansion of a reserved encoding is don't care
    if (!exp_illegal) begin
      check_value({name, " instr"}, exp_instr, dec_o.instr);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_behavior;
    int errors_before;
    errors_before = error_count;
    // valid word offered while reset is held
    @(posedge clk);
    fetch_i <= '{valid: 1'b1, rdata: 32'h0000_0013};
    repeat (RESET_CYCLES - 2) @(posedge clk);
    @(negedge clk);
    check_value("reset valid", 32'd0, 32'(dec_o.valid));
    @(posedge clk);
    reset_i <= 1'b0;
    fetch_i <= '0;
    @(posedge clk);
    @(negedge clk);
    check_value("idle after reset valid", 32'd0, 32'(dec_o.valid));
    report_test("reset", errors_before);
  endtask

  task automatic quadrant0_expansion;
    int errors_before;
    errors_before = error_count;
    apply_parcel("c.addi4spn x10, 584", 16'h04a8, 32'h2481_0513, 1'b0);
    apply_parcel("c.lw x11, 100(x12)", 16'h526c, 32'h0646_2583, 1'b0);
    apply_parcel("c.sw x15, 72(x8)", 16'hc43c, 32'h04f4_2423, 1'b0);
    // reserved quadrant 0 slots
    apply_parcel("c.addi4spn zero imm", 16'h0004, '0, 1'b1);
    apply_parcel("q0 funct3 001", 16'h2004, '0, 1'b1);
    apply_parcel("q0 funct3 100", 16'h8004, '0, 1'b1);
    apply_parcel("q0 funct3 111", 16'he004, '0, 1'b1);
    report_test("quadrant0", errors_before);
  endtask

  task automatic quadrant1_expansion;
    int errors_before;
    errors_before = error_count;
    apply_parcel("c.addi x10, -3", 16'h1575, 32'hffd5_0513, 1'b0);
    apply_parcel("c.nop", 16'h0001, 32'h0000_0013, 1'b0);
    apply_parcel("c.jal 34", 16'h200d, 32'h0220_00ef, 1'b0);
    apply_parcel("c.j -16", 16'hbfc5, 32'hff1f_f06f, 1'b0);
    apply_parcel("c.li x5, 17", 16'h42c5, 32'h0110_0293, 1'b0);
    apply_parcel("c.lui x6, -1", 16'h737d, 32'hffff_f337, 1'b0);
    apply_parcel("c.addi16sp -64", 16'h7139, 32'hfc01_0113, 1'b0);
    apply_parcel("c.srli x8, 3", 16'h800d, 32'h0034_5413, 1'b0);
    apply_parcel("c.srai x9, 31", 16'h84fd, 32'h41f4_d493, 1'b0);
    apply_parcel("c.andi x10, -8", 16'h9961, 32'hff85_7513, 1'b0);
    apply_parcel("c.sub x11, x12", 16'h8d91, 32'h40c5_85b3, 1'b0);
    apply_parcel("c.xor x13, x14", 16'h8eb9, 32'h00e6_c6b3, 1'b0);
    apply_parcel("c.or x14, x15", 16'h8f5d, 32'h00f7_6733, 1'b0);
    apply_parcel("c.and x15, x8", 16'h8fe1, 32'h0087_f7b3, 1'b0);
    apply_parcel("c.beqz x8, 8", 16'hc401, 32'h0004_0463, 1'b0);
    apply_parcel("c.bnez x9, -4", 16'hfcf5, 32'hfe04_9ee3, 1'b0);
    apply_parcel("c.lui x6, 0", 16'h6301, '0, 1'b1);
    apply_parcel("c.mul slot", 16'h9c41, '0, 1'b1);
    report_test("quadrant1", errors_before);
  endtask

  task automatic quadrant2_expansion;
    int errors_before;
    errors_before = error_count;
    apply_parcel("c.slli x5, 7", 16'h029e, 32'h0072_9293, 1'b0);
    apply_parcel("c.lwsp x6, 68", 16'h4316, 32'h0441_2303, 1'b0);
    apply_parcel("c.jr x7", 16'h8382, 32'h0003_8067, 1'b0);
    apply_parcel("c.mv x8, x9", 16'h8426, 32'h0090_0433, 1'b0);
    apply_parcel("c.ebreak", 16'h9002, 32'h0010_0073, 1'b0);
    apply_parcel("c.jalr x10", 16'h9502, 32'h0005_00e7, 1'b0);
    apply_parcel("c.add x11, x12", 16'h95b2, 32'h00c5_85b3, 1'b0);
    apply_parcel("c.swsp x13, 132", 16'hc336, 32'h08d1_2223, 1'b0);
    // hint form, decodes as a legal add to x0
    apply_parcel("c.mv x0, x9", 16'h8026, 32'h0090_0033, 1'b0);
    apply_parcel("c.lwsp x0", 16'h4002, '0, 1'b1);
    apply_parcel("c.jr x0", 16'h8002, '0, 1'b1);
    report_test("quadrant2", errors_before);
  endtask

  // back to back full-width words, one checked per cycle
  task automatic passthrough_stream;
    fetch_t word;
    fetch_t prev;
    int     errors_before;
    errors_before = error_count;
    word = '0;
    prev = '0;
    for (int i = 0; i <= STREAM_LEN; i++) begin
      @(posedge clk);
      if (i < STREAM_LEN) begin
        word.rdata      = $random(seed);
        word.rdata[1:0] = QUAD_RV32;
        // bubble every fifth slot
        word.valid      = (i % 5 != 3);
        fetch_i <= word;
      end
      @(negedge clk);
      if (i > 0) begin
        check_value($sformatf("stream %0d valid", i - 1), 32'(prev.valid), 32'(dec_o.valid));
        if (prev.valid) begin
          check_value($sformatf("stream %0d instr", i - 1), prev.rdata, dec_o.instr);
          check_value($sformatf("stream %0d flags", i - 1), 32'd0,
                      32'({dec_o.is_compressed, dec_o.illegal}));
        end
      end
      prev = word;
    end
    report_test("passthrough stream", errors_before);
  endtask

  initial begin
    int total_errors;
    seed    = 32'h3c0aeeb3;
    reset_i = 1'b1;
    fetch_i = '0;
    reset_behavior();
    quadrant0_expansion();
    quadrant1_expansion();
    quadrant2_expansion();
    passthrough_stream();
    total_errors = error_count
                   + compressed_decoder_stage_inst.compressed_decoder_asserts_inst.fail_count;
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, total_errors);
    if (total_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/c0_decoder.sv */
module c0_decoder (
  input  riscv_isa_pkg::instr16_t  cinstr_i,
  output cdec_pkg::quad_result_t   result_o
);

  import riscv_isa_pkg::*;

  // compressed register fields
  creg_t     rdp_c;
  creg_t     rs1p_c;
  // same fields widened to x8..x15
  reg_addr_t rdp;
  reg_addr_t rs1p;

  // rd' sits in 4:2, also serves as rs2' for c.sw
  assign rdp_c  = cinstr_i[4:2];
  assign rs1p_c = cinstr_i[9:7];
  assign rdp    = {CREG_BASE, rdp_c};
  assign rs1p   = {CREG_BASE, rs1p_c};

  //////////////////////////////////////////////////////////////////////
  // quadrant 0 expansion
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o.illegal = 1'b0;
    // lw shape as a harmless filler for reserved slots
    result_o.instr   = {5'b0, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00,
                        rs1p, 3'b010, rdp, OPCODE_LOAD};

    unique case (cinstr_i[15:13])
      3'b000: begin
        // c.addi4spn becomes addi rd', x2, nzuimm
        result_o.instr = {2'b0, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5], cinstr_i[6],
                          2'b00, REG_SP, 3'b000, rdp, OPCODE_OPIMM};
        // zero immediate is reserved
        if (cinstr_i[12:5] == 8'b0) begin
          result_o.illegal = 1'b1;
        end
      end
      3'b010: begin
        // c.lw keeps the filler shape, lw rd', uimm(rs1')
        result_o.illegal = 1'b0;
      end
      3'b110: begin
        // c.sw becomes sw rs2', uimm(rs1')
        result_o.instr = {5'b0, cinstr_i[5], cinstr_i[12], rdp, rs1p, 3'b010,
                          cinstr_i[11:10], cinstr_i[6], 2'b00, OPCODE_STORE};
      end
      default: begin
        // fld/flw/fsd/fsw and the old zc slots
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

/* verilog/c1_decoder.sv */
module c1_decoder (
  input  riscv_isa_pkg::instr16_t  cinstr_i,
  output cdec_pkg::quad_result_t   result_o
);

  import riscv_isa_pkg::*;

  // full rd/rs1 field of the ci and cj forms
  reg_addr_t   rd;
  // compressed fields of the cb and ca forms
  creg_t       rdp_c;
  creg_t       rs2p_c;
  reg_addr_t   rdp;
  reg_addr_t   rs2p;
  // 6 bit immediate sign extended to the i-type width
  logic [11:0] imm_ci;
  // link register of c.jal, x0 for c.j
  reg_addr_t   jal_rd;

  assign rd     = cinstr_i[11:7];
  assign rdp_c  = cinstr_i[9:7];
  assign rs2p_c = cinstr_i[4:2];
  assign rdp    = {CREG_BASE, rdp_c};
  assign rs2p   = {CREG_BASE, rs2p_c};
  assign imm_ci = {{6{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:2]};
  // bit 15 tells c.j from c.jal
  assign jal_rd = cinstr_i[15] ? REG_ZERO : REG_RA;

  //////////////////////////////////////////////////////////////////////
  // quadrant 1 expansion
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o.illegal = 1'b0;
    result_o.instr   = {imm_ci, rd, 3'b000, rd, OPCODE_OPIMM};

    unique case (cinstr_i[15:13])
      3'b000: begin
        // c.addi and c.nop keep the default addi rd, rd, imm
        result_o.illegal = 1'b0;
      end
      3'b001, 3'b101: begin
        // c.jal / c.j, offset bits scattered over 12:2
        result_o.instr = {cinstr_i[12], cinstr_i[8], cinstr_i[10:9], cinstr_i[6],
                          cinstr_i[7], cinstr_i[2], cinstr_i[11], cinstr_i[5:3],
                          {9{cinstr_i[12]}}, jal_rd, OPCODE_JAL};
      end
      3'b010: begin
        // c.li becomes addi rd, x0, imm, rd of x0 is a hint
        result_o.instr = {imm_ci, REG_ZERO, 3'b000, rd, OPCODE_OPIMM};
      end
      3'b011: begin
        if (rd == REG_SP) begin
          // c.addi16sp, immediate scaled by 16
          result_o.instr = {{3{cinstr_i[12]}}, cinstr_i[4:3], cinstr_i[5], cinstr_i[2],
                            cinstr_i[6], 4'b0, REG_SP, 3'b000, REG_SP, OPCODE_OPIMM};
        end else begin
          // c.lui, upper immediate sign extended from bit 17
          result_o.instr = {{15{cinstr_i[12]}}, cinstr_i[6:2], rd, OPCODE_LUI};
        end
        // both forms reserve the zero immediate
        if ({cinstr_i[12], cinstr_i[6:2]} == 6'b0) begin
          result_o.illegal = 1'b1;
        end
      end
      3'b100: begin
        unique case (cinstr_i[11:10])
          2'b00, 2'b01: begin
            // c.srli / c.srai, bit 10 picks the arithmetic shift
            result_o.instr = {1'b0, cinstr_i[10], 5'b0, cinstr_i[6:2], rdp, 3'b101, rdp,
                              OPCODE_OPIMM};
            // shamt[5] has no meaning on rv32
            if (cinstr_i[12]) begin
              result_o.illegal = 1'b1;
            end
          end
          2'b10: begin
            // c.andi
            result_o.instr = {imm_ci, rdp, 3'b111, rdp, OPCODE_OPIMM};
          end
          default: begin
            // register-register ops on x8..x15
            unique case ({cinstr_i[12], cinstr_i[6:5]})
              3'b000: result_o.instr = {7'b0100000, rs2p, rdp, 3'b000, rdp, OPCODE_OP};
              3'b001: result_o.instr = {7'b0, rs2p, rdp, 3'b100, rdp, OPCODE_OP};
              3'b010: result_o.instr = {7'b0, rs2p, rdp, 3'b110, rdp, OPCODE_OP};
              3'b011: result_o.instr = {7'b0, rs2p, rdp, 3'b111, rdp, OPCODE_OP};
              default: begin
                // subw, addw, c.mul and the zc unary slots
                result_o.illegal = 1'b1;
              end
            endcase
          end
        endcase
      end
      default: begin
        // c.beqz / c.bnez against x0, bit 13 selects bne
        result_o.instr = {{4{cinstr_i[12]}}, cinstr_i[6:5], cinstr_i[2], REG_ZERO, rdp,
                          2'b00, cinstr_i[13], cinstr_i[11:10], cinstr_i[4:3],
                          cinstr_i[12], OPCODE_BRANCH};
      end
    endcase
  end

endmodule

/* verilog/c2_decoder.sv */
module c2_decoder (
  input  riscv_isa_pkg::instr16_t  cinstr_i,
  output cdec_pkg::quad_result_t   result_o
);

  import riscv_isa_pkg::*;

  // full register fields of the cr/ci/css forms
  reg_addr_t rd;
  reg_addr_t rs2;

  assign rd  = cinstr_i[11:7];
  assign rs2 = cinstr_i[6:2];

  //////////////////////////////////////////////////////////////////////
  // quadrant 2 expansion
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o.illegal = 1'b0;
    // lwsp shape, also used as filler for the reserved slots
    result_o.instr   = {4'b0, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00,
                        REG_SP, 3'b010, rd, OPCODE_LOAD};

    unique case (cinstr_i[15:13])
      3'b000: begin
        // c.slli, zero shamt or rd of x0 are hints
        result_o.instr = {7'b0, rs2, rd, 3'b001, rd, OPCODE_OPIMM};
        if (cinstr_i[12]) begin
          result_o.illegal = 1'b1;
        end
      end
      3'b010: begin
        // c.lwsp, loading into x0 is reserved
        if (rd == REG_ZERO) begin
          result_o.illegal = 1'b1;
        end
      end
      3'b100: begin
        if (!cinstr_i[12]) begin
          if (rs2 == REG_ZERO) begin
            // c.jr, rs1 of x0 is reserved
            result_o.instr = {12'b0, rd, 3'b000, REG_ZERO, OPCODE_JALR};
            if (rd == REG_ZERO) begin
              result_o.illegal = 1'b1;
            end
          end else begin
            // c.mv becomes add rd, x0, rs2
            result_o.instr = {7'b0, rs2, REG_ZERO, 3'b000, rd, OPCODE_OP};
          end
        end else begin
          if (rs2 == REG_ZERO) begin
            if (rd == REG_ZERO) begin
              result_o.instr = EBREAK_INSTR;
            end else begin
              // c.jalr links through x1
              result_o.instr = {12'b0, rd, 3'b000, REG_RA, OPCODE_JALR};
            end
          end else begin
            // c.add, rd of x0 is a hint
            result_o.instr = {7'b0, rs2, rd, 3'b000, rd, OPCODE_OP};
          end
        end
      end
      3'b110: begin
        // c.swsp, offset split around rs2
        result_o.instr = {4'b0, cinstr_i[8:7], cinstr_i[12], rs2, REG_SP, 3'b010,
                          cinstr_i[11:9], 2'b00, OPCODE_STORE};
      end
      default: begin
        // fp stack-relative slots and the old zc loads
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

/* verilog/cdec_pkg.sv */
package cdec_pkg;

  //////////////////////////////////////////////////////////////////////
  // decoder interface structs
  //////////////////////////////////////////////////////////////////////

  // word coming from the fetch side, valid is a plain level
  typedef struct packed {
    logic                  valid;
    riscv_isa_pkg::instr32_t rdata;
  } fetch_t;

  // what each quadrant decoder hands back to the stage
  typedef struct packed {
    riscv_isa_pkg::instr32_t instr;
    // reserved or unsupported encoding
    logic                  illegal;
  } quad_result_t;

  // registered stage output toward decode
  typedef struct packed {
    logic                  valid;
    riscv_isa_pkg::instr32_t instr;
    // set when the word came from a 16 bit parcel
    logic                  is_compressed;
    logic                  illegal;
  } dec_out_t;

endpackage

/* verilog/compressed_decoder_stage.sv */
module compressed_decoder_stage (
  input  logic               clk,
  input  logic               reset_i,
  input  cdec_pkg::fetch_t   fetch_i,
  output cdec_pkg::dec_out_t dec_o
);

  import riscv_isa_pkg::*;
  import cdec_pkg::*;

  // low parcel, shared by all three decoders
  instr16_t     cinstr;
  // per-quadrant results and the chosen one
  quad_result_t c0_result;
  quad_result_t c1_result;
  quad_result_t c2_result;
  quad_result_t sel_result;
  // next value of the output register
  dec_out_t     dec_d;

  assign cinstr = fetch_i.rdata[15:0];

  //////////////////////////////////////////////////////////////////////
  // quadrant decoders
  //////////////////////////////////////////////////////////////////////

  c0_decoder c0_decoder_inst (
    .cinstr_i (cinstr),
    .result_o (c0_result)
  );

  c1_decoder c1_decoder_inst (
    .cinstr_i (cinstr),
    .result_o (c1_result)
  );

  c2_decoder c2_decoder_inst (
    .cinstr_i (cinstr),
    .result_o (c2_result)
  );

  // quadrant select on bits 1:0, the decoders never test them
  always_comb begin
    unique case (fetch_i.rdata[1:0])
      QUAD_C0: sel_result = c0_result;
      QUAD_C1: sel_result = c1_result;
      QUAD_C2: sel_result = c2_result;
      QUAD_RV32: begin
        // full word passes through untouched
        sel_result.instr   = fetch_i.rdata;
        sel_result.illegal = 1'b0;
      end
    endcase
  end

  assign dec_d.valid         = fetch_i.valid;
  assign dec_d.instr         = sel_result.instr;
  assign dec_d.is_compressed = (fetch_i.rdata[1:0] != QUAD_RV32);
  assign dec_d.illegal       = sel_result.illegal;

  // one cycle of latency, a new word every cycle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      dec_o <= '0;
    end else begin
      dec_o <= dec_d;
    end
  end

endmodule

/* verilog/riscv_isa_pkg.sv */
package riscv_isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // instruction word and field types
  //////////////////////////////////////////////////////////////////////

  // one full rv32 instruction
  typedef logic [31:0] instr32_t;

  // one compressed parcel, the low half of a fetched word
  typedef logic [15:0] instr16_t;

  // major opcode, bits 6:0 of an rv32 word
  typedef logic [6:0] opcode_t;

  // architectural register index
  typedef logic [4:0] reg_addr_t;

  // compressed register index, only reaches x8 to x15
  typedef logic [2:0] creg_t;

  //////////////////////////////////////////////////////////////////////
  // major opcodes used by the expansion
  //////////////////////////////////////////////////////////////////////

  localparam opcode_t OPCODE_OPIMM  = 7'h13;
  localparam opcode_t OPCODE_OP     = 7'h33;
  localparam opcode_t OPCODE_LUI    = 7'h37;
  localparam opcode_t OPCODE_LOAD   = 7'h03;
  localparam opcode_t OPCODE_STORE  = 7'h23;
  localparam opcode_t OPCODE_JAL    = 7'h6f;
  localparam opcode_t OPCODE_JALR   = 7'h67;
  localparam opcode_t OPCODE_BRANCH = 7'h63;

  // fixed registers named by the compressed forms
  localparam reg_addr_t REG_ZERO = 5'd0;
  localparam reg_addr_t REG_RA   = 5'd1;
  localparam reg_addr_t REG_SP   = 5'd2;

  // prefix that widens a compressed index into x8..x15
  localparam logic [1:0] CREG_BASE = 2'b01;

  // full-width ebreak
  localparam instr32_t EBREAK_INSTR = 32'h0010_0073;

  // quadrant code, bits 1:0 of the fetched word
  localparam logic [1:0] QUAD_C0   = 2'b00;
  localparam logic [1:0] QUAD_C1   = 2'b01;
  localparam logic [1:0] QUAD_C2   = 2'b10;
  localparam logic [1:0] QUAD_RV32 = 2'b11;

endpackage
